// File: logic/cmd_pkg.sv
package cmd_pkg;

    localparam int word_w     = 16;   // Memory word.
    localparam int data_w     = 32;   // Register value.
    localparam int addr_w     = 10;   // 1024 words in each memory.
    localparam int reg_addr_w = 14;

    // Opcode field is bits 15:14 of a command word.
    localparam logic [1:0] op_write = 2'b10;
    localparam logic [1:0] op_read  = 2'b00;

    localparam int out_limit = 800;   // Result pointer that ends a run.

    localparam int reg_count = 16;
    localparam int reg_sel_w = $clog2(reg_count);   // Address bits the bank decodes.
    localparam int reg_wait  = 2;
    localparam int wait_w    = $clog2(reg_wait + 1);

endpackage

// File: logic/word_ram.sv
`timescale 1ns/1ps

module word_ram (
    input  logic                       clk,
    input  logic                       we,
    input  logic [cmd_pkg::addr_w-1:0] waddr,
    input  logic [cmd_pkg::word_w-1:0] wdata,
    input  logic [cmd_pkg::addr_w-1:0] raddr,
    output logic [cmd_pkg::word_w-1:0] rdata
);

    logic [cmd_pkg::word_w-1:0] mem [0:2**cmd_pkg::addr_w-1];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];   // Old word on a same-address collision.
    end

endmodule

// File: logic/list_pointers.sv
`timescale 1ns/1ps

module list_pointers (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clear_ptrs,
    input  logic                       load_len,
    input  logic                       in_step,
    input  logic                       out_step,
    input  logic [cmd_pkg::word_w-1:0] len_word,
    output logic [cmd_pkg::addr_w-1:0] in_ptr,
    output logic [cmd_pkg::addr_w-1:0] out_ptr,
    output logic                       in_room,
    output logic                       out_room
);

    logic [cmd_pkg::word_w-1:0] list_len;

    always_ff @(posedge clk)
    begin
        if (rst || clear_ptrs)
        begin
            in_ptr   <= '0;
            list_len <= '0;
        end
        else if (load_len)
        begin
            list_len <= len_word;
            in_ptr   <= cmd_pkg::addr_w'(1);   // First command follows the header.
        end
        else if (in_step)
        begin
            in_ptr <= in_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || clear_ptrs)
            out_ptr <= '0;
        else if (out_step)
            out_ptr <= out_ptr + 1'b1;
    end

    assign in_room  = int'(in_ptr) < int'(list_len);   // Header word counts in L.
    assign out_room = int'(out_ptr) < cmd_pkg::out_limit;

    // A read that passes the check just below the limit still stores both
    // halves of its value, so the pointer may run two words past out_limit.
    out_ptr_bound: assert property (@(posedge clk) disable iff (rst)
        out_step |-> int'(out_ptr) < cmd_pkg::out_limit + 2)
        else $error("result pointer stepped past its bound");

endmodule

// File: logic/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start_valid,
    output logic                           busy,
    output logic                           done,
    output logic                           err,
    output logic [cmd_pkg::addr_w-1:0]     out_len,
    input  logic [cmd_pkg::word_w-1:0]     cmd_q,
    output logic                           res_we,
    output logic [cmd_pkg::word_w-1:0]     res_d,
    output logic                           clear_ptrs,
    output logic                           load_len,
    output logic                           in_step,
    output logic                           out_step,
    input  logic [cmd_pkg::addr_w-1:0]     in_ptr,
    input  logic [cmd_pkg::addr_w-1:0]     out_ptr,
    input  logic                           in_room,
    input  logic                           out_room,
    output logic [cmd_pkg::reg_addr_w-1:0] reg_addr,
    output logic                           reg_rd,
    output logic                           reg_wr,
    output logic [cmd_pkg::data_w-1:0]     reg_writedata,
    input  logic                           reg_ready,
    input  logic [cmd_pkg::data_w-1:0]     reg_readdata
);

    typedef enum logic [3:0] {
        st_idle,
        st_len_fetch,
        st_cmd_check,
        st_cmd_decode,
        st_wr_high,
        st_wr_low,
        st_wr_wait,
        st_rd_wait,
        st_res_high,
        st_res_low
    } state_t;

    state_t                     state;
    state_t                     next_state;
    logic [1:0]                 opcode;
    logic [1:0]                 cmd_op;
    logic [cmd_pkg::word_w-1:0] list_len;
    logic [cmd_pkg::data_w-1:0] write_val;
    logic [cmd_pkg::data_w-1:0] read_val;
    logic                       start;
    logic                       run_ok;
    logic                       run_end;
    logic                       len_miss;
    logic                       req_wait;

    assign cmd_op   = cmd_q[15:14];
    assign start    = (state == st_idle) && start_valid && !busy;
    assign run_ok   = in_room && out_room;
    assign run_end  = (state == st_cmd_check) && !run_ok;
    assign len_miss = int'(in_ptr) != int'(list_len);   // List not consumed exactly.
    assign req_wait = (state == st_wr_wait) || (state == st_rd_wait);

    always_comb
    begin
        next_state = state;
        case (state)
            st_idle:
                if (start)
                    next_state = st_len_fetch;
            st_len_fetch:
                next_state = st_cmd_check;
            st_cmd_check:
                next_state = run_ok ? st_cmd_decode : st_idle;
            st_cmd_decode:
                if (cmd_op == cmd_pkg::op_write)
                    next_state = st_wr_high;
                else if (cmd_op == cmd_pkg::op_read)
                    next_state = st_rd_wait;
                else
                    next_state = st_cmd_check;   // Marks are only echoed.
            st_wr_high:
                next_state = st_wr_low;
            st_wr_low:
                next_state = st_wr_wait;
            st_wr_wait:
                if (reg_ready)
                    next_state = st_cmd_check;
            st_rd_wait:
                if (reg_ready)
                    next_state = st_res_high;
            st_res_high:
                next_state = st_res_low;
            st_res_low:
                next_state = st_cmd_check;
            default:
                next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= st_idle;
        else
            state <= next_state;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy    <= 1'b0;
            done    <= 1'b0;
            err     <= 1'b0;
            out_len <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;   // Falls the cycle after done.
            if (run_end)
            begin
                done    <= 1'b1;
                err     <= len_miss;
                out_len <= len_miss ? '0 : out_ptr;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == st_len_fetch)
            list_len <= cmd_q;
        if (state == st_cmd_decode)
        begin
            opcode   <= cmd_op;
            reg_addr <= cmd_q[cmd_pkg::reg_addr_w-1:0];
        end
        if (state == st_wr_high)
            write_val[cmd_pkg::data_w-1 -: cmd_pkg::word_w] <= cmd_q;
        if (state == st_wr_low)
            write_val[cmd_pkg::word_w-1:0] <= cmd_q;
        if (reg_rd && reg_ready)
            read_val <= reg_readdata;   // Held until both halves are stored.
    end

    // Rewinding at the end leaves word 0 on cmd_q for the next start.
    assign clear_ptrs = run_end;
    assign load_len   = (state == st_len_fetch);

    // Steps land a cycle ahead of the registered read, so the high and low
    // words of a write reach cmd_q in st_wr_high and st_wr_low.
    assign in_step = (state == st_cmd_check && run_ok)
                  || (state == st_cmd_decode && cmd_op == cmd_pkg::op_write)
                  || (state == st_wr_high);

    assign res_we   = (state == st_cmd_decode) || (state == st_res_high)
                   || (state == st_res_low);
    assign out_step = res_we;

    always_comb
    begin
        case (state)
            st_res_high: res_d = read_val[cmd_pkg::data_w-1 -: cmd_pkg::word_w];
            st_res_low:  res_d = read_val[cmd_pkg::word_w-1:0];
            default:     res_d = cmd_q;   // Command echo.
        endcase
    end

    // Request type comes from the opcode latched at decode.
    assign reg_rd        = req_wait && (opcode == cmd_pkg::op_read);
    assign reg_wr        = req_wait && (opcode == cmd_pkg::op_write);
    assign reg_writedata = write_val;

    req_held: assert property (@(posedge clk) disable iff (rst)
        (reg_rd || reg_wr) && !reg_ready |=> (reg_rd || reg_wr) && $stable(reg_addr)
            && $stable(reg_writedata))
        else $error("register request changed before ready");

    req_only_busy: assert property (@(posedge clk) disable iff (rst)
        (reg_rd || reg_wr) |-> busy)
        else $error("register request outside a run");

endmodule

// File: logic/reg_bank.sv
`timescale 1ns/1ps

module reg_bank (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [cmd_pkg::reg_addr_w-1:0] reg_addr,
    input  logic                           reg_rd,
    input  logic                           reg_wr,
    input  logic [cmd_pkg::data_w-1:0]     reg_writedata,
    output logic                           reg_ready,
    output logic [cmd_pkg::data_w-1:0]     reg_readdata
);

    logic [cmd_pkg::data_w-1:0]    regs [0:cmd_pkg::reg_count-1];
    logic [cmd_pkg::wait_w-1:0]    wait_cnt;
    logic [cmd_pkg::reg_sel_w-1:0] sel;
    logic                          req;
    logic                          last_wait;

    assign sel       = reg_addr[cmd_pkg::reg_sel_w-1:0];   // Upper bits alias.
    assign req       = reg_rd || reg_wr;
    assign last_wait = int'(wait_cnt) == cmd_pkg::reg_wait;

    // Ready comes reg_wait+1 cycles after the request rises and lasts one cycle.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wait_cnt  <= '0;
            reg_ready <= 1'b0;
        end
        else if (reg_ready)
        begin
            wait_cnt  <= '0;
            reg_ready <= 1'b0;
        end
        else if (req)
        begin
            if (last_wait)
                reg_ready <= 1'b1;
            else
                wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req && !reg_ready && last_wait)
            reg_readdata <= regs[sel];   // Valid in the ready cycle.
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < cmd_pkg::reg_count; i++)
                regs[i] <= '0;
        end
        else if (reg_ready && reg_wr)
        begin
            regs[sel] <= reg_writedata;
        end
    end

    ready_needs_req: assert property (@(posedge clk) disable iff (rst)
        reg_ready |-> req)
        else $error("ready raised without a request");

endmodule

// File: logic/cmd_exec_top.sv
`timescale 1ns/1ps

module cmd_exec_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_wr_en,
    input  logic [cmd_pkg::addr_w-1:0] cmd_wr_addr,
    input  logic [cmd_pkg::word_w-1:0] cmd_wr_data,
    input  logic [cmd_pkg::addr_w-1:0] res_rd_addr,
    output logic [cmd_pkg::word_w-1:0] res_rd_data,
    input  logic                       start_valid,
    output logic                       start_ready,
    output logic                       busy,
    output logic                       done,
    output logic                       err,
    output logic [cmd_pkg::addr_w-1:0] out_len
);

    logic [cmd_pkg::word_w-1:0]     cmd_q;
    logic                           res_we;
    logic [cmd_pkg::word_w-1:0]     res_d;
    logic                           clear_ptrs;
    logic                           load_len;
    logic                           in_step;
    logic                           out_step;
    logic [cmd_pkg::addr_w-1:0]     in_ptr;
    logic [cmd_pkg::addr_w-1:0]     out_ptr;
    logic                           in_room;
    logic                           out_room;
    logic [cmd_pkg::reg_addr_w-1:0] reg_addr;
    logic                           reg_rd;
    logic                           reg_wr;
    logic [cmd_pkg::data_w-1:0]     reg_writedata;
    logic                           reg_ready;
    logic [cmd_pkg::data_w-1:0]     reg_readdata;

    assign start_ready = !busy;

    // Command list, loaded by the host.
    word_ram u_cmd_ram (
        .clk   (clk),
        .we    (cmd_wr_en),
        .waddr (cmd_wr_addr),
        .wdata (cmd_wr_data),
        .raddr (in_ptr),
        .rdata (cmd_q)
    );

    word_ram u_res_ram (
        .clk   (clk),
        .we    (res_we),
        .waddr (out_ptr),
        .wdata (res_d),
        .raddr (res_rd_addr),
        .rdata (res_rd_data)
    );

    list_pointers u_ptrs (
        .clk        (clk),
        .rst        (rst),
        .clear_ptrs (clear_ptrs),
        .load_len   (load_len),
        .in_step    (in_step),
        .out_step   (out_step),
        .len_word   (cmd_q),
        .in_ptr     (in_ptr),
        .out_ptr    (out_ptr),
        .in_room    (in_room),
        .out_room   (out_room)
    );

    cmd_sequencer u_seq (
        .clk           (clk),
        .rst           (rst),
        .start_valid   (start_valid),
        .busy          (busy),
        .done          (done),
        .err           (err),
        .out_len       (out_len),
        .cmd_q         (cmd_q),
        .res_we        (res_we),
        .res_d         (res_d),
        .clear_ptrs    (clear_ptrs),
        .load_len      (load_len),
        .in_step       (in_step),
        .out_step      (out_step),
        .in_ptr        (in_ptr),
        .out_ptr       (out_ptr),
        .in_room       (in_room),
        .out_room      (out_room),
        .reg_addr      (reg_addr),
        .reg_rd        (reg_rd),
        .reg_wr        (reg_wr),
        .reg_writedata (reg_writedata),
        .reg_ready     (reg_ready),
        .reg_readdata  (reg_readdata)
    );

    reg_bank u_regs (
        .clk           (clk),
        .rst           (rst),
        .reg_addr      (reg_addr),
        .reg_rd        (reg_rd),
        .reg_wr        (reg_wr),
        .reg_writedata (reg_writedata),
        .reg_ready     (reg_ready),
        .reg_readdata  (reg_readdata)
    );

endmodule

// File: verif/cmd_exec_tb.sv
`timescale 1ns/1ps

module cmd_exec_tb;

    localparam int num_rows = 6;

    logic                       clk;
    logic                       rst;
    logic                       cmd_wr_en;
    logic [cmd_pkg::addr_w-1:0] cmd_wr_addr;
    logic [cmd_pkg::word_w-1:0] cmd_wr_data;
    logic [cmd_pkg::addr_w-1:0] res_rd_addr;
    logic [cmd_pkg::word_w-1:0] res_rd_data;
    logic                       start_valid;
    logic                       start_ready;
    logic                       busy;
    logic                       done;
    logic                       err;
    logic [cmd_pkg::addr_w-1:0] out_len;

    // Test table. Word list is packed with the first command in the top bits.
    string        names [0:num_rows-1];
    int           lens [0:num_rows-1];
    logic         exp_errs [0:num_rows-1];
    logic [127:0] row_words [0:num_rows-1];
    int           n_words [0:num_rows-1];
    logic [15:0]  rep_word [0:num_rows-1];
    int           rep_cnt [0:num_rows-1];

    // Reference model state.
    logic [15:0] cmd_mem [0:1023];
    logic [31:0] model_regs [0:15];
    logic [15:0] exp_res [0:1023];
    int          exp_n;
    int          exp_len;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          watch_cycles;

    cmd_exec_top uut (
        .clk         (clk),
        .rst         (rst),
        .cmd_wr_en   (cmd_wr_en),
        .cmd_wr_addr (cmd_wr_addr),
        .cmd_wr_data (cmd_wr_data),
        .res_rd_addr (res_rd_addr),
        .res_rd_data (res_rd_data),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .busy        (busy),
        .done        (done),
        .err         (err),
        .out_len     (out_len)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic set_row(input int r, input string name, input int len, input logic e,
                           input logic [127:0] w, input int n, input logic [15:0] rw,
                           input int rc);
        names[r]     = name;
        lens[r]      = len;
        exp_errs[r]  = e;
        row_words[r] = w;
        n_words[r]   = n;
        rep_word[r]  = rw;
        rep_cnt[r]   = rc;
    endtask

    task automatic fill_table();
        set_row(0, "write_read", 9, 1'b0, {16'h8003, 16'h1234, 16'h5678, 16'h8007,
                16'hdead, 16'hbeef, 16'h0003, 16'h0007}, 8, 16'h0, 0);
        set_row(1, "pass_through", 6, 1'b0, {16'h4abc, 16'hc123, 16'h0003, 16'h0005,
                16'h7fff, 48'h0}, 5, 16'h0, 0);
        set_row(2, "alias", 6, 1'b0, {16'hbff9, 16'ha5a5, 16'h0f0f, 16'h0009,
                16'h1239, 48'h0}, 5, 16'h0, 0);   // 0x3ff9 and 0x1239 both hit r9.
        set_row(3, "short_write", 3, 1'b1, {16'h8002, 16'h1111, 16'h2222, 80'h0},
                3, 16'h0, 0);   // Low half sits past L.
        set_row(4, "out_limit", 300, 1'b1, 128'h0, 0, 16'h0002, 299);
        set_row(5, "persist", 4, 1'b0, {16'h0002, 16'h0007, 16'h0009, 80'h0},
                3, 16'h0, 0);
    endtask

    task automatic load_list(input int r);
        int          total;
        logic [15:0] w;
        total = 1 + n_words[r] + rep_cnt[r];
        for (int k = 0; k < total; k++)
        begin
            if (k == 0)
                w = 16'(lens[r]);   // Header.
            else if (k <= n_words[r])
                w = row_words[r][127 - 16 * (k - 1) -: 16];
            else
                w = rep_word[r];
            cmd_mem[k] = w;
            @(posedge clk);
            cmd_wr_en   <= 1'b1;
            cmd_wr_addr <= cmd_pkg::addr_w'(k);
            cmd_wr_data <= w;
        end
        @(posedge clk);
        cmd_wr_en <= 1'b0;
    endtask

    // Walks the list the way the command-list rules describe.
    task automatic run_model(input int len);
        int          ip;
        int          op;
        logic [15:0] cmd;
        logic [31:0] v;
        ip = 1;
        op = 0;
        while (ip < len && op < cmd_pkg::out_limit)
        begin
            cmd = cmd_mem[ip];
            ip++;
            exp_res[op] = cmd;
            op++;
            if (cmd[15:14] == cmd_pkg::op_write)
            begin
                model_regs[cmd[3:0]] = {cmd_mem[ip], cmd_mem[ip + 1]};
                ip += 2;
            end
            else if (cmd[15:14] == cmd_pkg::op_read)
            begin
                v = model_regs[cmd[3:0]];
                exp_res[op]     = v[31:16];
                exp_res[op + 1] = v[15:0];
                op += 2;
            end
        end
        exp_n   = op;
        exp_len = (ip != len) ? 0 : op;
    endtask

    task automatic start_run();
        logic accepted;
        accepted = 1'b0;
        @(posedge clk);
        start_valid <= 1'b1;
        while (!accepted)
        begin
            @(negedge clk);
            accepted = start_ready;
            @(posedge clk);
        end
        start_valid <= 1'b0;
    endtask

    task automatic run_test(input int r);
        int first_err;
        first_err = errors;
        load_list(r);
        run_model(lens[r]);
        start_run();
        do @(negedge clk); while (!done);
        if (err !== exp_errs[r])
        begin
            $display("MISMATCH %s err: expected %0b, actual %0b", names[r], exp_errs[r], err);
            errors++;
        end
        if (out_len !== cmd_pkg::addr_w'(exp_len))
        begin
            $display("MISMATCH %s out_len: expected %0d, actual %0d", names[r], exp_len,
                     out_len);
            errors++;
        end
        @(negedge clk);
        if (done !== 1'b0 || busy !== 1'b0 || start_ready !== 1'b1)
        begin
            $display("Test %s: the DUT did not return to idle one cycle after done.",
                     names[r]);
            errors++;
        end
        for (int i = 0; i < exp_n; i++)
        begin
            @(posedge clk);
            res_rd_addr <= cmd_pkg::addr_w'(i);
            @(posedge clk);
            @(negedge clk);
            if (res_rd_data !== exp_res[i])
            begin
                $display("MISMATCH %s result[%0d]: expected %h, actual %h", names[r], i,
                         exp_res[i], res_rd_data);
                errors++;
            end
        end
        if (errors == first_err)
        begin
            tests_passed++;
            $display("PASS %s (%0d result words)", names[r], exp_n);
        end
        else
        begin
            tests_failed++;
            $display("FAIL %s (%0d errors)", names[r], errors - first_err);
        end
    endtask

    initial
    begin
        @(negedge rst);
        repeat (watch_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles.", watch_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        rst          = 1'b1;
        cmd_wr_en    = 1'b0;
        cmd_wr_addr  = '0;
        cmd_wr_data  = '0;
        res_rd_addr  = '0;
        start_valid  = 1'b0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        watch_cycles = 0;
        for (int i = 0; i < 16; i++)
            model_regs[i] = '0;
        fill_table();
        for (int r = 0; r < num_rows; r++)
            watch_cycles += 20 * (1 + n_words[r] + rep_cnt[r]);
        watch_cycles += 500;   // Reset and slack.
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b0 || done !== 1'b0 || err !== 1'b0 || out_len !== '0)
        begin
            $display("Status outputs were not cleared by reset.");
            errors++;
        end
        for (int r = 0; r < num_rows; r++)
            run_test(r);
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d", tests_passed,
                 tests_failed, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: build.f
logic/cmd_pkg.sv
logic/word_ram.sv
logic/list_pointers.sv
logic/cmd_sequencer.sv
logic/reg_bank.sv
logic/cmd_exec_top.sv
verif/cmd_exec_tb.sv
